// ==== include/elevator_defines.svh ====
/*
 * Sizing macros for the elevator floor request controller.
 * Floors are numbered from 0 (lowest) to FLOOR_COUNT-1.
 * FLOOR_W must be wide enough to hold FLOOR_COUNT-1.
 * QUEUE_DEPTH equals FLOOR_COUNT. A floor is queued at most once
 * while its light is on, so the queue cannot overflow.
 */
`ifndef ELEVATOR_DEFINES_SVH
`define ELEVATOR_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Building size
//////////////////////////////////////////////////////////////////////

// Number of served floors
`define FLOOR_COUNT 11

// Bits needed for a floor index
`define FLOOR_W 4

//////////////////////////////////////////////////////////////////////
// Request storage
//////////////////////////////////////////////////////////////////////

// One slot per floor is always enough
`define QUEUE_DEPTH `FLOOR_COUNT

`endif

// ==== logic/elevator_pkg.sv ====
/*
 * Shared types of the floor request controller.
 * Widths come from elevator_defines.svh.
 * The car reports only its floor and whether it is moving;
 * the detailed motion state stays in the car's own controller.
 */
`include "elevator_defines.svh"

package elevator_pkg;

    //////////////////////////////////////////////////////////////////
    // Plain vectors
    //////////////////////////////////////////////////////////////////

    // Floor index, 0 is the lowest floor
    typedef logic [`FLOOR_W-1:0] floor_t;

    // One bit per floor, for buttons and lights
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    //////////////////////////////////////////////////////////////////
    // Records between the stages and toward the car
    //////////////////////////////////////////////////////////////////

    // Item passed from capture through the queue to dispatch
    typedef struct packed {
        floor_t floor;
    } floor_request_t;

    // Move command, up is set when the target lies above the car
    typedef struct packed {
        floor_t target;
        logic   up;
    } move_cmd_t;

    // What the car tells us about itself
    typedef struct packed {
        floor_t floor;
        logic   moving;
    } car_status_t;

    // Dispatch FSM
    typedef enum logic [1:0] {
        IDLE,
        OFFER,
        TRAVEL,
        ARRIVE
    } dispatch_state_t;

endpackage

// ==== logic/request_capture.sv ====
/*
 * Button capture stage.
 * A press counts only with power on, no emergency, neither light of
 * that floor lit and the car not stopped at that floor.
 * Lit floors are offered to the queue lowest first. An offer that is
 * not taken is held, so valid and data stay stable until transfer.
 * Power off clears lights and pending floors at every edge.
 */
`timescale 1ns/1ps
`include "elevator_defines.svh"

module request_capture import elevator_pkg::*; (
    input  logic           clock,
    input  logic           reset_n,
    input  floor_mask_t    call_buttons,
    input  floor_mask_t    panel_buttons,
    input  car_status_t    car,
    input  logic           power_on,
    input  logic           emergency,
    input  floor_t         served_floor,
    input  logic           served_valid,
    input  logic           capture_ready,
    output floor_mask_t    call_lights,
    output floor_mask_t    panel_lights,
    output floor_request_t capture_request,
    output logic           capture_valid
);

    // Decode a floor index into its mask bit
    function automatic floor_mask_t floor_onehot(input floor_t f);
        floor_mask_t m;
        m = '0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (f == floor_t'(i)) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

    floor_mask_t pending;
    floor_mask_t stopped_mask;
    floor_mask_t served_mask;
    floor_mask_t take_mask;
    floor_mask_t new_call;
    floor_mask_t new_panel;
    floor_mask_t accept_mask;
    floor_t      lowest_pending;
    floor_t      hold_floor;
    logic        hold_valid;
    logic        transfer;

    //////////////////////////////////////////////////////////////////
    // Press qualification
    //////////////////////////////////////////////////////////////////

    // Floor where the car stands still, empty while it moves
    assign stopped_mask = car.moving ? '0 : floor_onehot(car.floor);
    assign served_mask  = served_valid ? floor_onehot(served_floor) : '0;

    // A floor is blocked if either of its lights is on
    assign accept_mask = {`FLOOR_COUNT{power_on && !emergency}}
                       & ~(call_lights | panel_lights)
                       & ~stopped_mask;

    assign new_call  = call_buttons & accept_mask;
    assign new_panel = panel_buttons & accept_mask;

    //////////////////////////////////////////////////////////////////
    // Offer toward the queue
    //////////////////////////////////////////////////////////////////

    // Lowest pending floor wins
    always_comb begin
        lowest_pending = '0;
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (pending[i]) begin
                lowest_pending = floor_t'(i);
            end
        end
    end

    assign capture_valid         = |pending;
    assign capture_request.floor = hold_valid ? hold_floor : lowest_pending;
    assign transfer              = capture_valid && capture_ready;
    assign take_mask             = transfer ? floor_onehot(capture_request.floor) : '0;

    //////////////////////////////////////////////////////////////////
    // Lights and pending floors
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
            pending      <= '0;
            hold_valid   <= 1'b0;
        end else if (!power_on) begin
            call_lights  <= '0;
            panel_lights <= '0;
            pending      <= '0;
            hold_valid   <= 1'b0;
        end else begin
            call_lights  <= (call_lights | new_call) & ~served_mask;
            panel_lights <= (panel_lights | new_panel) & ~served_mask;
            pending      <= (pending | new_call | new_panel) & ~take_mask;
            // Freeze the offered floor while the queue pushes back
            hold_valid   <= capture_valid && !capture_ready;
        end
    end

    // Offered floor, only meaningful while hold_valid is set
    always_ff @(posedge clock) begin
        hold_floor <= capture_request.floor;
    end

endmodule

// ==== logic/request_queue.sv ====
/*
 * Circular FIFO of floor requests with valid/ready on both sides.
 * Push and pop may happen in the same cycle.
 * A pushed entry shows up at the head one cycle later.
 * flush empties the queue at the next edge and wins over a push.
 * DEPTH may be any value of 1 or more.
 */
`timescale 1ns/1ps
`include "elevator_defines.svh"

module request_queue import elevator_pkg::*; #(
    parameter int DEPTH = `QUEUE_DEPTH
) (
    input  logic           clock,
    input  logic           reset_n,
    input  logic           flush,
    input  floor_request_t capture_request,
    input  logic           capture_valid,
    output logic           capture_ready,
    output floor_request_t head_request,
    output logic           head_valid,
    input  logic           head_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    // Advance a pointer with wrap at the last slot
    function automatic ptr_t next_ptr(input ptr_t p);
        ptr_t n;
        if (p == ptr_t'(DEPTH - 1)) begin
            n = '0;
        end else begin
            n = p + ptr_t'(1);
        end
        return n;
    endfunction

    floor_request_t mem [DEPTH];
    ptr_t           wr_ptr;
    ptr_t           rd_ptr;
    count_t         count;
    logic           push;
    logic           pop;

    //////////////////////////////////////////////////////////////////
    // Handshakes
    //////////////////////////////////////////////////////////////////

    assign capture_ready = (count != count_t'(DEPTH));
    assign head_valid    = (count != '0);
    assign head_request  = mem[rd_ptr];

    assign push = capture_valid && capture_ready;
    assign pop  = head_valid && head_ready;

    //////////////////////////////////////////////////////////////////
    // Pointers and fill level
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leave the level unchanged
            if (push && !pop) begin
                count <= count + count_t'(1);
            end else if (pop && !push) begin
                count <= count - count_t'(1);
            end
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= capture_request;
        end
    end

endmodule

// ==== logic/floor_dispatch.sv ====
/*
 * Dispatch stage. Takes one request at a time from the queue and
 * issues a move command to the car with valid/ready.
 * A request for the floor where the car already stands skips the
 * move and is reported served at once.
 * An offered command is held until accepted, even under emergency.
 * Door permissions are combinational from the buttons.
 */
`timescale 1ns/1ps

module floor_dispatch import elevator_pkg::*; (
    input  logic           clock,
    input  logic           reset_n,
    input  logic           power_on,
    input  logic           emergency,
    input  car_status_t    car,
    input  floor_request_t head_request,
    input  logic           head_valid,
    output logic           head_ready,
    output move_cmd_t      move_cmd,
    output logic           move_valid,
    input  logic           move_ready,
    output floor_t         served_floor,
    output logic           served_valid,
    input  logic           door_open_button,
    input  logic           door_close_button,
    output logic           door_open_allowed,
    output logic           door_close_allowed
);

    dispatch_state_t state;
    dispatch_state_t state_next;
    move_cmd_t       cmd;
    logic            take;
    logic            at_car;
    logic            arrived;
    logic            doors_free;

    //////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////

    // Only pull a new floor when the car is idle and it is safe
    assign head_ready = (state == IDLE) && power_on && !emergency && !car.moving;
    assign take       = head_valid && head_ready;
    assign at_car     = (head_request.floor == car.floor);

    // Car stopped at the commanded floor
    assign arrived = !car.moving && (car.floor == cmd.target);

    assign move_cmd     = cmd;
    assign move_valid   = (state == OFFER);
    assign served_floor = cmd.target;
    assign served_valid = (state == ARRIVE);

    //////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (take) begin
                    state_next = at_car ? ARRIVE : OFFER;
                end
            end
            OFFER: begin
                if (move_ready) begin
                    state_next = TRAVEL;
                end
            end
            TRAVEL: begin
                if (arrived) begin
                    state_next = ARRIVE;
                end
            end
            ARRIVE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else if (!power_on) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Command payload, captured when the head is popped
    always_ff @(posedge clock) begin
        if (take) begin
            cmd.target <= head_request.floor;
            cmd.up     <= (head_request.floor > car.floor);
        end
    end

    //////////////////////////////////////////////////////////////////
    // Door permission
    //////////////////////////////////////////////////////////////////

    assign doors_free         = power_on && !car.moving && (state != TRAVEL);
    assign door_open_allowed  = door_open_button && doors_free;
    assign door_close_allowed = door_close_button && doors_free;

endmodule

// ==== logic/floor_request_controller.sv ====
/*
 * Floor request controller top level.
 * Pipeline of capture, queue and dispatch joined by valid/ready.
 * power_on low flushes every stage at each edge.
 * The car's motion controller sits outside and answers move_ready.
 */
`timescale 1ns/1ps

module floor_request_controller import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t call_buttons,
    input  floor_mask_t panel_buttons,
    input  car_status_t car,
    input  logic        power_on,
    input  logic        emergency,
    input  logic        door_open_button,
    input  logic        door_close_button,
    output floor_mask_t call_lights,
    output floor_mask_t panel_lights,
    output move_cmd_t   move_cmd,
    output logic        move_valid,
    input  logic        move_ready,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    // Capture to queue
    floor_request_t capture_request;
    logic           capture_valid;
    logic           capture_ready;

    // Queue to dispatch
    floor_request_t head_request;
    logic           head_valid;
    logic           head_ready;

    // Dispatch back to capture
    floor_t         served_floor;
    logic           served_valid;

    request_capture i_request_capture (
        .clock           (clock),
        .reset_n         (reset_n),
        .call_buttons    (call_buttons),
        .panel_buttons   (panel_buttons),
        .car             (car),
        .power_on        (power_on),
        .emergency       (emergency),
        .served_floor    (served_floor),
        .served_valid    (served_valid),
        .capture_ready   (capture_ready),
        .call_lights     (call_lights),
        .panel_lights    (panel_lights),
        .capture_request (capture_request),
        .capture_valid   (capture_valid)
    );

    request_queue i_request_queue (
        .clock           (clock),
        .reset_n         (reset_n),
        .flush           (!power_on),
        .capture_request (capture_request),
        .capture_valid   (capture_valid),
        .capture_ready   (capture_ready),
        .head_request    (head_request),
        .head_valid      (head_valid),
        .head_ready      (head_ready)
    );

    floor_dispatch i_floor_dispatch (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_on           (power_on),
        .emergency          (emergency),
        .car                (car),
        .head_request       (head_request),
        .head_valid         (head_valid),
        .head_ready         (head_ready),
        .move_cmd           (move_cmd),
        .move_valid         (move_valid),
        .move_ready         (move_ready),
        .served_floor       (served_floor),
        .served_valid       (served_valid),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// ==== verification/floor_request_controller_sva.sv ====
/*
 * Handshake and door assertions, bound to the controller top level.
 * Stability checks are suspended during reset and while power is off,
 * because power off flushes every stage.
 */
`timescale 1ns/1ps

module floor_request_controller_sva import elevator_pkg::*; (
    input logic           clock,
    input logic           reset_n,
    input logic           power_on,
    input car_status_t    car,
    input move_cmd_t      move_cmd,
    input logic           move_valid,
    input logic           move_ready,
    input floor_request_t head_request,
    input logic           head_valid,
    input logic           head_ready,
    input logic           door_open_allowed,
    input logic           door_close_allowed
);

    // Offered move command stays put until the car takes it
    move_hold: assert property (@(posedge clock) disable iff (!reset_n || !power_on)
        move_valid && !move_ready |=> move_valid && $stable(move_cmd))
        else $error("move command changed before acceptance");

    head_hold: assert property (@(posedge clock) disable iff (!reset_n || !power_on)
        head_valid && !head_ready |=> head_valid && $stable(head_request))
        else $error("queue head changed before transfer");

    move_quiet_in_reset: assert property (@(posedge clock) !reset_n |-> !move_valid)
        else $error("move_valid high during reset");

    // No door permission while the car moves
    doors_shut_moving: assert property (@(posedge clock) disable iff (!reset_n)
        car.moving |-> !door_open_allowed && !door_close_allowed)
        else $error("door permitted while car moving");

endmodule

bind floor_request_controller floor_request_controller_sva i_sva (.*);

// ==== verification/floor_request_controller_tb.sv ====
/*
 * Table-driven testbench for the floor request controller.
 * A behavioral car accepts commands after a random delay and walks
 * one floor every two cycles. Rows marked settle wait until the car
 * is idle and all lights are off, so their expected lights are exact.
 */
`timescale 1ns/1ps
`include "elevator_defines.svh"

module floor_request_controller_tb import elevator_pkg::*;;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_ROWS   = 10;
    localparam int ROW_CYCLES = 200;

    typedef struct packed {
        logic        settle;
        logic        power;
        logic        emergency;
        logic        door_open;
        logic        door_close;
        floor_mask_t call;
        floor_mask_t panel;
        floor_mask_t exp_call;
        floor_mask_t exp_panel;
    } row_t;

    logic        clock;
    logic        reset_n;
    floor_mask_t call_buttons;
    floor_mask_t panel_buttons;
    car_status_t car;
    logic        power_on;
    logic        emergency;
    logic        door_open_button;
    logic        door_close_button;
    floor_mask_t call_lights;
    floor_mask_t panel_lights;
    move_cmd_t   move_cmd;
    logic        move_valid;
    logic        move_ready;
    logic        door_open_allowed;
    logic        door_close_allowed;

    row_t        rows [NUM_ROWS];
    floor_t      exp_targets [$];
    logic        traveling;
    int          errors;

    floor_request_controller i_dut (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////

    task automatic check_mask(input string name, input floor_mask_t got, input floor_mask_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_move(input string name, input move_cmd_t got, input move_cmd_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Wait for an idle car and dark lights
    task automatic wait_idle();
        do begin
            @(negedge clock);
        end while (car.moving || move_valid || traveling || ((call_lights | panel_lights) != '0));
        repeat (3) @(negedge clock);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Car model
    ////////////////////////////////////////////////////////////////////

    initial begin : car_model
        move_cmd_t held;
        move_cmd_t expected;
        int        delay;
        int        pos;
        floor_t    prev_target;
        logic      have_prev;
        pos       = 0;
        have_prev = 1'b0;
        prev_target = '0;
        forever begin
            @(negedge clock);
            if (move_valid) begin
                held  = move_cmd;
                delay = $urandom_range(3, 0);
                repeat (delay) begin
                    @(negedge clock);
                    check_move("move_cmd", move_cmd, held);
                end
                // Previous floor must be dark before the next command
                if (have_prev) begin
                    check_bit("served_light", call_lights[prev_target] | panel_lights[prev_target],
                              1'b0);
                end
                if (exp_targets.size() == 0) begin
                    $display("Unexpected move command to floor %0d", held.target);
                    errors++;
                end else begin
                    expected.target = exp_targets.pop_front();
                    expected.up     = (int'(expected.target) > pos);
                    check_move("move_cmd", held, expected);
                end
                @(posedge clock);
                move_ready <= 1'b1;
                @(posedge clock);
                move_ready <= 1'b0;
                traveling  <= 1'b1;
                car        <= '{floor: floor_t'(pos), moving: 1'b1};
                while (pos != int'(held.target)) begin
                    repeat (2) @(posedge clock);
                    pos = (int'(held.target) > pos) ? pos + 1 : pos - 1;
                    car <= '{floor: floor_t'(pos), moving: (pos != int'(held.target))};
                end
                @(posedge clock);
                traveling   <= 1'b0;
                prev_target = held.target;
                have_prev   = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////////////

    initial begin
        #(NUM_ROWS * ROW_CYCLES * CLK_PERIOD);
        $display("Timeout, the test did not finish in time");
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic exp_free;
        void'($urandom(32'hadd6_dc88));
        errors            = 0;
        clock             = 1'b0;
        reset_n           = 1'b0;
        call_buttons      = '0;
        panel_buttons     = '0;
        car               = '{floor: '0, moving: 1'b0};
        power_on          = 1'b1;
        emergency         = 1'b0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        move_ready        = 1'b0;
        traveling         = 1'b0;

        // settle, power, emergency, door open, door close, call, panel,
        // call lights, panel lights
        rows[0] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 11'h001, 11'h000, 11'h000, 11'h000};
        rows[1] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 11'h088, 11'h008, 11'h088, 11'h008};
        rows[2] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 11'h028, 11'h000, 11'h0a8, 11'h008};
        rows[3] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 11'h000, 11'h204, 11'h000, 11'h204};
        rows[4] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 11'h002, 11'h000, 11'h000, 11'h000};
        rows[5] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 11'h010, 11'h000, 11'h010, 11'h000};
        // Emergency arrives before the queued floor can be taken
        rows[6] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 11'h000, 11'h000, 11'h010, 11'h000};
        rows[7] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 11'h040, 11'h000, 11'h000, 11'h000};
        rows[8] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 11'h001, 11'h200, 11'h001, 11'h000};
        rows[9] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 11'h000, 11'h000, 11'h000, 11'h000};

        // Lowest floor first in a cycle, then first-press order
        exp_targets.push_back(floor_t'(3));
        exp_targets.push_back(floor_t'(7));
        exp_targets.push_back(floor_t'(5));
        exp_targets.push_back(floor_t'(2));
        exp_targets.push_back(floor_t'(9));
        exp_targets.push_back(floor_t'(0));

        repeat (3) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check_bit("move_valid", move_valid, 1'b0);
        check_mask("call_lights", call_lights, '0);
        check_mask("panel_lights", panel_lights, '0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].settle) begin
                wait_idle();
            end
            @(posedge clock);
            call_buttons      <= rows[r].call;
            panel_buttons     <= rows[r].panel;
            power_on          <= rows[r].power;
            emergency         <= rows[r].emergency;
            door_open_button  <= rows[r].door_open;
            door_close_button <= rows[r].door_close;
            @(posedge clock);
            call_buttons  <= '0;
            panel_buttons <= '0;
            @(negedge clock);
            check_mask("call_lights", call_lights, rows[r].exp_call);
            check_mask("panel_lights", panel_lights, rows[r].exp_panel);
            exp_free = power_on && !car.moving && !traveling;
            check_bit("door_open_allowed", door_open_allowed, rows[r].door_open && exp_free);
            check_bit("door_close_allowed", door_close_allowed, rows[r].door_close && exp_free);
        end

        door_open_button  <= 1'b0;
        door_close_button <= 1'b0;
        wait_idle();
        if (exp_targets.size() != 0) begin
            $display("Expected %0d more move commands that never came", exp_targets.size());
            errors++;
        end

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
logic/elevator_pkg.sv
logic/request_capture.sv
logic/request_queue.sv
logic/floor_dispatch.sv
logic/floor_request_controller.sv
verification/floor_request_controller_sva.sv
verification/floor_request_controller_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the floor request controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f sources.f \
    --top-module floor_request_controller_tb \
    && ./obj_dir/Vfloor_request_controller_tb | grep -q "^No errors$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
